//--- src/tone_cfg_pkg.sv
package tone_cfg_pkg;

   // width of the phase accumulator and of the frequency word
   localparam int PHASE_W = 16;

   // waveform select, two bits
   typedef enum logic [1:0]
   {
      wave_sine     = 2'd0,
      wave_triangle = 2'd1,
      wave_square   = 2'd2,
      wave_saw      = 2'd3
   } wave_sel_e;

   // tone setup, held stable while run is high
   typedef struct packed
   {
      logic [PHASE_W-1:0] freq;  // phase increment per step
      wave_sel_e          wave;  // selected waveform
   } tone_cfg_t;

endpackage

//--- src/sample_pkg.sv
package sample_pkg;

   // unsigned DAC code width
   localparam int SAMPLE_W = 6;

   // entries in the quarter-wave sine table
   localparam int QUARTER_N = 32;

   // one sample as it moves from producer to pacer
   typedef struct packed
   {
      logic [SAMPLE_W-1:0]   code;  // DAC code
      tone_cfg_pkg::wave_sel_e wave;  // waveform that made it, kept for tracing
   } sample_t;

endpackage

//--- src/sine_quarter_rom.sv
module sine_quarter_rom
(
   input  logic                              clk,
   input  logic                              rstn,
   input  logic                              en,
   input  logic [4:0]                        addr,
   output logic [sample_pkg::SAMPLE_W-1:0]   data_out
);

   localparam int W = sample_pkg::SAMPLE_W;

   // first quadrant of a sine of amplitude 31, rising from zero
   localparam logic [W-1:0] QTABLE [sample_pkg::QUARTER_N] = '{
      6'd0,  6'd2,  6'd3,  6'd5,  6'd6,  6'd8,  6'd9,  6'd11,
      6'd12, 6'd14, 6'd15, 6'd16, 6'd18, 6'd19, 6'd20, 6'd21,
      6'd22, 6'd24, 6'd25, 6'd25, 6'd26, 6'd27, 6'd28, 6'd28,
      6'd29, 6'd30, 6'd30, 6'd30, 6'd31, 6'd31, 6'd31, 6'd31
   };

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         data_out <= '0;
      end
      else
      begin
         if (en)
         begin
            data_out <= QTABLE[addr];  // one cycle read latency
         end
         else
         begin
            data_out <= '0;  // idle table reads as zero
         end
      end
   end

endmodule

//--- src/tone_producer.sv
module tone_producer
(
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    run,
   input  tone_cfg_pkg::tone_cfg_t cfg,
   input  logic                    afull,
   output logic                    push,
   output sample_pkg::sample_t     sample
);

   localparam int PW = tone_cfg_pkg::PHASE_W;
   localparam int SW = sample_pkg::SAMPLE_W;
   localparam logic [SW-1:0] MID = SW'(1 << (SW - 1));  // midscale of the DAC
   localparam logic [SW-1:0] SQ_HI = '1;
   localparam logic [SW-1:0] SQ_LO = SW'(1);

   logic [PW-1:0]           phase;
   logic [6:0]              p;
   logic                    step;
   logic [4:0]              rom_addr;
   logic                    rom_en;
   logic [SW-1:0]           rom_data;
   logic                    s1_valid;
   logic [1:0]              s1_quad;
   logic [4:0]              s1_idx;
   tone_cfg_pkg::wave_sel_e s1_wave;
   logic [4:0]              s1_fold;
   logic [SW-1:0]           code_next;

   assign step = run && !afull;  // stall the phase under back-pressure
   assign p = phase[PW-1 -: 7];  // 2 quadrant bits over a 5-bit index

   // falling quadrants read the table backwards
   assign rom_addr = p[5] ? ~p[4:0] : p[4:0];
   assign rom_en = step && (cfg.wave == tone_cfg_pkg::wave_sine);

   sine_quarter_rom u_rom
   (
      .clk      (clk),
      .rstn     (rstn),
      .en       (rom_en),
      .addr     (rom_addr),
      .data_out (rom_data)
   );

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         phase    <= '0;
         s1_valid <= 1'b0;
         push     <= 1'b0;
      end
      else
      begin
         if (step)
         begin
            phase <= phase + cfg.freq;  // wraps naturally
         end
         s1_valid <= step;
         push     <= s1_valid;  // two cycles after the step
      end
   end

   // stage 1 carries the pre-step phase next to the table output
   always_ff @(posedge clk)
   begin
      s1_quad <= p[6:5];
      s1_idx  <= p[4:0];
      s1_wave <= cfg.wave;
   end

   assign s1_fold = s1_quad[0] ? ~s1_idx : s1_idx;

   always_comb
   begin
      case (s1_wave)
         tone_cfg_pkg::wave_sine:
            code_next = s1_quad[1] ? MID - rom_data : MID + rom_data;
         tone_cfg_pkg::wave_triangle:
            code_next = s1_quad[1] ? MID - SW'(s1_fold) : MID + SW'(s1_fold);
         tone_cfg_pkg::wave_square:
            code_next = s1_quad[1] ? SQ_LO : SQ_HI;  // high for the first half cycle
         default:
            code_next = {s1_quad, s1_idx[4:1]};  // saw is the phase halved
      endcase
   end

   always_ff @(posedge clk)
   begin
      sample.code <= code_next;
      sample.wave <= s1_wave;
   end

   // the tone setup only changes between runs
   a_cfg_stable_in_run: assert property (@(posedge clk) disable iff (!rstn)
      run |-> $stable(cfg));

endmodule

//--- src/sample_fifo.sv
module sample_fifo #(
   parameter int DEPTH = 8
)
(
   input  logic                clk,
   input  logic                rstn,
   input  logic                push,
   input  sample_pkg::sample_t din,
   input  logic                pop,
   output sample_pkg::sample_t dout,
   output logic                empty,
   output logic                afull
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [CNT_W-1:0] AFULL_LVL = CNT_W'(DEPTH - 3);  // fewer than 3 free above this

   sample_pkg::sample_t mem [DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [CNT_W-1:0]    count;
   logic                full;

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two so the pointer wraps
         end
         if (pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign dout  = mem[rd_ptr];  // head entry, valid while not empty
   assign empty = (count == '0);
   assign full  = (count == CNT_W'(DEPTH));
   assign afull = (count > AFULL_LVL);

   a_no_push_full: assert property (@(posedge clk) disable iff (!rstn) push |-> !full);
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn) pop |-> !empty);

endmodule

//--- src/sample_pacer.sv
module sample_pacer #(
   parameter int RATE_DIV = 6
)
(
   input  logic                            clk,
   input  logic                            rstn,
   input  logic                            run,
   input  logic                            empty,
   input  sample_pkg::sample_t             head,
   output logic                            pop,
   output logic [sample_pkg::SAMPLE_W-1:0] dac_code,
   output logic                            dac_strobe
);

   localparam int DIV_W = $clog2(RATE_DIV);
   localparam logic [DIV_W-1:0] TC = DIV_W'(RATE_DIV - 1);

   logic [DIV_W-1:0] div;
   logic             at_tc;

   assign at_tc = (div == TC);
   assign pop   = run && at_tc && !empty;

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         div        <= '0;
         dac_code   <= '0;
         dac_strobe <= 1'b0;
      end
      else
      begin
         if (!run)
         begin
            div <= '0;  // a pause restarts the full period
         end
         else if (!at_tc)
         begin
            div <= div + 1'b1;
         end
         else if (!empty)
         begin
            div <= '0;
         end
         // at the terminal count with nothing queued the divider waits
         if (pop)
         begin
            dac_code <= head.code;  // held until the next strobe
         end
         dac_strobe <= pop;
      end
   end

   a_strobe_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
      dac_strobe |=> !dac_strobe);

endmodule

//--- src/wave_gen_top.sv
module wave_gen_top #(
   parameter int FIFO_DEPTH = 8,
   parameter int RATE_DIV   = 6
)
(
   input  logic                            clk,
   input  logic                            rstn,
   input  logic                            run,
   input  tone_cfg_pkg::tone_cfg_t         cfg,
   output logic [sample_pkg::SAMPLE_W-1:0] dac_code,
   output logic                            dac_strobe
);

   logic                push;
   logic                pop;
   logic                empty;
   logic                afull;
   sample_pkg::sample_t prod_sample;
   sample_pkg::sample_t head;

   tone_producer u_producer
   (
      .clk    (clk),
      .rstn   (rstn),
      .run    (run),
      .cfg    (cfg),
      .afull  (afull),
      .push   (push),
      .sample (prod_sample)
   );

   sample_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo
   (
      .clk   (clk),
      .rstn  (rstn),
      .push  (push),
      .din   (prod_sample),
      .pop   (pop),
      .dout  (head),
      .empty (empty),
      .afull (afull)
   );

   sample_pacer #(.RATE_DIV(RATE_DIV)) u_pacer
   (
      .clk        (clk),
      .rstn       (rstn),
      .run        (run),
      .empty      (empty),
      .head       (head),
      .pop        (pop),
      .dac_code   (dac_code),
      .dac_strobe (dac_strobe)
   );

endmodule

//--- verification/wave_gen_tb.sv
module wave_gen_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int FIFO_DEPTH     = 8;
   localparam int RATE_DIV       = 6;
   localparam int SW             = sample_pkg::SAMPLE_W;
   localparam int PW             = tone_cfg_pkg::PHASE_W;
   localparam int NUM_SEG        = 16;
   localparam int NUM_BURST      = 4;
   localparam int RESET_CYCLES   = 16;
   localparam int STROBE_TIMEOUT = 8 * RATE_DIV;
   localparam logic [15:0] LFSR_SEED = 16'd3109;
   localparam logic [15:0] LFSR_TAPS = 16'hB400;  // x^16 + x^14 + x^13 + x^11 + 1

   // quarter-wave sine magnitudes, amplitude 31
   localparam logic [SW-1:0] SINE_Q [sample_pkg::QUARTER_N] = '{
      6'd0,  6'd2,  6'd3,  6'd5,  6'd6,  6'd8,  6'd9,  6'd11,
      6'd12, 6'd14, 6'd15, 6'd16, 6'd18, 6'd19, 6'd20, 6'd21,
      6'd22, 6'd24, 6'd25, 6'd25, 6'd26, 6'd27, 6'd28, 6'd28,
      6'd29, 6'd30, 6'd30, 6'd30, 6'd31, 6'd31, 6'd31, 6'd31
   };

   logic                    clk;
   logic                    rstn;
   logic                    run;
   tone_cfg_pkg::tone_cfg_t cfg;
   logic [SW-1:0]           dac_code;
   logic                    dac_strobe;

   logic [15:0]   lfsr_state;
   int            errors = 0;
   int            timeouts = 0;
   int            strobe_count = 0;
   logic [PW-1:0] model_phase;
   logic [SW-1:0] exp_code;
   logic          prev_run;
   logic          seen_run;
   logic          steady;  // run stayed high since the last strobe
   int            gap;

   wave_gen_top #(.FIFO_DEPTH(FIFO_DEPTH), .RATE_DIV(RATE_DIV)) DUT
   (
      .clk        (clk),
      .rstn       (rstn),
      .run        (run),
      .cfg        (cfg),
      .dac_code   (dac_code),
      .dac_strobe (dac_strobe)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0])
      begin
         n = n ^ LFSR_TAPS;
      end
      return n;
   endfunction

   // one register step for each bit taken and the first bit ends up as the msb
   task automatic take_bits(input int n, output logic [15:0] val);
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         val = {val[14:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   // code for one phase, unfolded from the quarter table
   function automatic logic [SW-1:0] expected_code(input logic [PW-1:0] phase,
                                                   input tone_cfg_pkg::wave_sel_e wave);
      logic [6:0]    p;
      logic [4:0]    fold;
      logic [SW-1:0] mag;
      logic [SW-1:0] code;
      p = phase[PW-1 -: 7];
      fold = p[5] ? 5'd31 - p[4:0] : p[4:0];  // quadrants 1 and 3 run backwards
      mag = SINE_Q[fold];
      case (wave)
         tone_cfg_pkg::wave_sine:
            code = p[6] ? SW'(32) - mag : SW'(32) + mag;
         tone_cfg_pkg::wave_triangle:
            code = p[6] ? SW'(32) - {1'b0, fold} : SW'(32) + {1'b0, fold};
         tone_cfg_pkg::wave_square:
            code = (p < 7'd64) ? SW'(63) : SW'(1);
         default:
            code = p[6:1];
      endcase
      return code;
   endfunction

   task automatic tick(input int n);
      repeat (n)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_strobe();
      int start;
      int waited;
      start = strobe_count;
      waited = 0;
      while (strobe_count == start && waited < STROBE_TIMEOUT)
      begin
         tick(1);
         waited++;
      end
      if (strobe_count == start)
      begin
         timeouts++;
         $display("timeout: no DAC strobe within %0d cycles of run", STROBE_TIMEOUT);
      end
   endtask

   // outputs are sampled on the falling edge, half a cycle after they settle
   always @(negedge clk)
   begin
      if (!rstn)
      begin
         model_phase = '0;
         prev_run = 1'b0;
         seen_run = 1'b0;
         steady = 1'b0;
         gap = 0;
      end
      else
      begin
         if (!seen_run && (dac_strobe || dac_code != '0))
         begin
            errors++;
            $display("ERR %0t: output active before run, strobe %0b code %0d",
                     $time, dac_strobe, dac_code);
         end
         if (dac_strobe)
         begin
            strobe_count++;
            if (!prev_run)
            begin
               errors++;
               $display("ERR %0t: strobe after a cycle with run low", $time);
            end
            exp_code = expected_code(model_phase, cfg.wave);
            if (dac_code !== exp_code)
            begin
               errors++;
               $display("ERR %0t: code %0d, expected %0d (wave %0d, phase 0x%04h)",
                        $time, dac_code, exp_code, cfg.wave, model_phase);
            end
            model_phase = model_phase + cfg.freq;  // next sample in strobe order
            if (steady && gap != RATE_DIV)
            begin
               errors++;
               $display("ERR %0t: strobe gap %0d cycles, expected %0d", $time, gap, RATE_DIV);
            end
            steady = 1'b1;
            gap = 0;
         end
         if (!run)
         begin
            steady = 1'b0;  // a pause restarts the divider
         end
         if (run)
         begin
            seen_run = 1'b1;
         end
         gap++;
         prev_run = run;
      end
   end

   initial
   begin
      logic [15:0] r;
      int          burst_len;
      int          pause_len;
      int          seg_start;
      rstn = 1'b0;
      run = 1'b0;
      cfg = '0;
      lfsr_state = LFSR_SEED;
      for (int seg = 0; seg < NUM_SEG; seg++)
      begin
         rstn = 1'b0;  // reset empties the FIFO before a new tone
         take_bits(2, r);
         cfg.wave = tone_cfg_pkg::wave_sel_e'((seg < 4) ? 2'(seg) : r[1:0]);
         take_bits(16, r);
         cfg.freq = r[PW-1:0];
         tick(RESET_CYCLES);
         rstn = 1'b1;
         tick(4);
         seg_start = strobe_count;
         for (int b = 0; b < NUM_BURST; b++)
         begin
            take_bits(10, r);
            burst_len = 12 + int'(r[9:0]);
            take_bits(4, r);
            pause_len = int'(r[3:0]);
            run = 1'b1;
            tick(burst_len);
            run = 1'b0;
            tick(pause_len);
         end
         run = 1'b1;
         wait_strobe();
         run = 1'b0;
         tick(2);
         if (strobe_count == seg_start)
         begin
            errors++;
            $display("no DAC strobe at all for tone %0d", seg);
         end
      end
      $display("closing: %0d errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
      begin
         $display("Verification passed");
      end
      else
      begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- filelist.f
src/tone_cfg_pkg.sv
src/sample_pkg.sv
src/sine_quarter_rom.sv
src/tone_producer.sv
src/sample_fifo.sv
src/sample_pacer.sv
src/wave_gen_top.sv
verification/wave_gen_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module wave_gen_tb -f filelist.f -o wave_gen_sim

out="$(./obj_dir/wave_gen_sim)"
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
   exit 0
fi
exit 1
